// File: rtl/memctl_params.svh
// Widths and RISC-V opcode and funct field values for the memory-system control unit
`ifndef MEMCTL_PARAMS_SVH
`define MEMCTL_PARAMS_SVH

// Instruction word width
`define MC_ILEN 32

// Address-space identifier width (SV39)
`define MC_ASID_LEN 16

// Virtual page number width, three 9-bit levels
`define MC_VPN_LEN 27

// Major opcodes
`define MC_OPCODE_FENCE 7'b0001111
`define MC_OPCODE_SYSTEM 7'b1110011

// MISC-MEM funct3 selecting FENCE.I
`define MC_FUNCT3_FENCE_I 3'b001

// SYSTEM funct7 selecting SFENCE.VMA
`define MC_FUNCT7_SFENCE_VMA 7'b0001001

`endif

// File: rtl/memctl_pkg.sv
// Event, command, TLB flush type and exception cause types of the memory-system control unit
`include "memctl_params.svh"

package memctl_pkg;

	// RISC-V exception causes seen by the unit
	typedef enum logic [3:0] {
		I_ADDR_MISALIGNED  = 4'd0,
		I_ACCESS_FAULT     = 4'd1,
		ILLEGAL_INSTR      = 4'd2,
		LD_ADDR_MISALIGNED = 4'd4,
		LD_ACCESS_FAULT    = 4'd5,
		ST_ADDR_MISALIGNED = 4'd6,
		ST_ACCESS_FAULT    = 4'd7,
		ECALL_S            = 4'd9,
		ECALL_M            = 4'd11,
		INSTR_PAGE_FAULT   = 4'd12,
		LD_PAGE_FAULT      = 4'd13,
		ST_PAGE_FAULT      = 4'd15
	} except_code_e;

	// Flush request toward the L1 and L2 TLBs
	typedef enum logic [1:0] {
		NO_FLUSH   = 2'd0,
		FLUSH_PAGE = 2'd1,
		FLUSH_ASID = 2'd2,
		FLUSH_ALL  = 2'd3
	} tlb_flush_e;

	// One retired event from the core
	typedef struct packed {
		// Set for a raised exception, clear for a retired instruction
		logic                      is_except;
		logic [`MC_ILEN-1:0]       instr;
		except_code_e              code;
		// rs2 value, or faulting ASID
		logic [`MC_ASID_LEN-1:0]   asid;
		// rs1 page, or faulting page
		logic [`MC_VPN_LEN-1:0]    vpn;
	} mc_event_t;

	// One maintenance command for the memory side
	typedef struct packed {
		// Clear L1/L2 TLB miss-status registers
		logic                      clr_tlb_mshr;
		// Clear d-cache MSHRs
		logic                      clr_dmshr;
		logic                      abort;
		// Sync L1 d-cache with L2 before release
		logic                      sync_l2;
		logic                      flush_pipe;
		tlb_flush_e                flush_type;
		logic [`MC_ASID_LEN-1:0]   flush_asid;
		logic [`MC_VPN_LEN-1:0]    flush_page;
	} mc_cmd_t;

endpackage

// File: rtl/memctl_decode.sv
// Decode stage: classifies a retired instruction or exception into a maintenance command
`timescale 1ns/1ps
`include "memctl_params.svh"

module memctl_decode (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  evt_valid_i,
	input  memctl_pkg::mc_event_t evt_i,
	output logic                  evt_ready_o,
	output logic                  cmd_valid_o,
	output memctl_pkg::mc_cmd_t   cmd_o,
	input  logic                  cmd_ready_i
);

	// Instruction fields
	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [4:0]          rs1_idx;
	logic [4:0]          rs2_idx;
	logic                is_fence_i;
	logic                is_sfence_vma;
	memctl_pkg::mc_cmd_t cmd_nxt;
	logic                has_action;

	assign opcode  = evt_i.instr[6:0];
	assign funct3  = evt_i.instr[14:12];
	assign rs1_idx = evt_i.instr[19:15];
	assign rs2_idx = evt_i.instr[24:20];
	assign funct7  = evt_i.instr[31:25];

	assign is_fence_i = (opcode == `MC_OPCODE_FENCE) && (funct3 == `MC_FUNCT3_FENCE_I);
	assign is_sfence_vma = (opcode == `MC_OPCODE_SYSTEM) && (funct3 == 3'd0) &&
		(funct7 == `MC_FUNCT7_SFENCE_VMA);

	// Command classification
	always_comb begin
		cmd_nxt = '0;
		if (evt_i.is_except) begin
			// Every exception redirects the pipeline
			cmd_nxt.flush_pipe = 1'b1;
			case (evt_i.code)
				memctl_pkg::I_ADDR_MISALIGNED,
				memctl_pkg::I_ACCESS_FAULT: begin
					cmd_nxt.clr_tlb_mshr = 1'b1;
				end
				memctl_pkg::INSTR_PAGE_FAULT: begin
					cmd_nxt.clr_tlb_mshr = 1'b1;
					cmd_nxt.flush_type   = memctl_pkg::FLUSH_PAGE;
					cmd_nxt.flush_page   = evt_i.vpn;
				end
				memctl_pkg::LD_ADDR_MISALIGNED,
				memctl_pkg::LD_ACCESS_FAULT,
				memctl_pkg::ST_ADDR_MISALIGNED,
				memctl_pkg::ST_ACCESS_FAULT: begin
					cmd_nxt.clr_dmshr = 1'b1;
				end
				memctl_pkg::LD_PAGE_FAULT,
				memctl_pkg::ST_PAGE_FAULT: begin
					cmd_nxt.clr_dmshr  = 1'b1;
					cmd_nxt.flush_type = memctl_pkg::FLUSH_PAGE;
					cmd_nxt.flush_page = evt_i.vpn;
				end
				memctl_pkg::ILLEGAL_INSTR: begin
					cmd_nxt.abort      = 1'b1;
					cmd_nxt.flush_type = memctl_pkg::FLUSH_ALL;
				end
				memctl_pkg::ECALL_S,
				memctl_pkg::ECALL_M: begin
					// Trap entry needs a coherent L2 view
					cmd_nxt.sync_l2    = 1'b1;
					cmd_nxt.flush_type = memctl_pkg::FLUSH_ALL;
				end
				default: begin
					// Breakpoint, U-mode ecall and reserved causes
					cmd_nxt.flush_type = memctl_pkg::FLUSH_ALL;
				end
			endcase
		end else if (is_fence_i) begin
			cmd_nxt.clr_tlb_mshr = 1'b1;
		end else if (is_sfence_vma) begin
			cmd_nxt.clr_tlb_mshr = 1'b1;
			cmd_nxt.clr_dmshr    = 1'b1;
			cmd_nxt.sync_l2      = 1'b1;
			// rs1 selects one page, else rs2 one address space
			if (rs1_idx != 5'd0) begin
				cmd_nxt.flush_type = memctl_pkg::FLUSH_PAGE;
				cmd_nxt.flush_page = evt_i.vpn;
			end else if (rs2_idx != 5'd0) begin
				cmd_nxt.flush_type = memctl_pkg::FLUSH_ASID;
				cmd_nxt.flush_asid = evt_i.asid;
			end else begin
				cmd_nxt.flush_type = memctl_pkg::FLUSH_ALL;
			end
		end
	end

	// Ordinary instructions leave every field clear
	assign has_action = cmd_nxt.clr_tlb_mshr | cmd_nxt.clr_dmshr | cmd_nxt.abort |
		cmd_nxt.sync_l2 | cmd_nxt.flush_pipe | (cmd_nxt.flush_type != memctl_pkg::NO_FLUSH);

	// Empty, or drained this cycle
	assign evt_ready_o = !cmd_valid_o || cmd_ready_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cmd_valid_o <= 1'b0;
		end else if (evt_ready_o) begin
			// No-action events are taken and dropped here
			cmd_valid_o <= evt_valid_i && has_action;
		end
	end

	// Payload
	always_ff @(posedge clk_i) begin
		if (evt_valid_i && evt_ready_o) begin
			cmd_o <= cmd_nxt;
		end
	end

endmodule

// File: rtl/memctl_execute.sv
// Execute stage: holds one command and runs the L1 d-cache / L2 synchronisation wait
`timescale 1ns/1ps

module memctl_execute (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	input  memctl_pkg::mc_cmd_t in_cmd_i,
	output logic                in_ready_o,
	output logic                out_valid_o,
	output memctl_pkg::mc_cmd_t out_cmd_o,
	input  logic                out_ready_i,
	output logic                sync_req_o,
	input  logic                sync_done_i
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_sync,
		st_hold
	} state_e;

	state_e state_q;
	state_e state_d;
	state_e entry_state;
	logic   load;

	// Free, or the held command leaves this cycle
	assign in_ready_o = (state_q == st_idle) || ((state_q == st_hold) && out_ready_i);
	assign load       = in_valid_i && in_ready_o;

	// A new command waits for L2 first when it asks for sync
	assign entry_state = in_cmd_i.sync_l2 ? st_wait_sync : st_hold;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (in_valid_i) begin
					state_d = entry_state;
				end
			end
			st_wait_sync: begin
				// Release on the L2 update unit's done pulse
				if (sync_done_i) begin
					state_d = st_hold;
				end
			end
			st_hold: begin
				if (out_ready_i) begin
					// Back-to-back refill keeps the stage full
					state_d = in_valid_i ? entry_state : st_idle;
				end
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// Held command
	always_ff @(posedge clk_i) begin
		if (load) begin
			out_cmd_o <= in_cmd_i;
		end
	end

	// Request stays up for the whole wait
	assign sync_req_o  = (state_q == st_wait_sync);
	assign out_valid_o = (state_q == st_hold);

endmodule

// File: rtl/memctl_result.sv
// Result stage: output holding register toward the TLBs and caches
`timescale 1ns/1ps

module memctl_result (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	input  memctl_pkg::mc_cmd_t in_cmd_i,
	output logic                in_ready_o,
	output logic                cmd_valid_o,
	output memctl_pkg::mc_cmd_t cmd_o,
	input  logic                cmd_ready_i
);

	logic load;

	// Empty, or the memory side takes the command now
	assign in_ready_o = !cmd_valid_o || cmd_ready_i;
	assign load       = in_valid_i && in_ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cmd_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			cmd_valid_o <= in_valid_i;
		end
	end

	// Command stays stable until taken
	always_ff @(posedge clk_i) begin
		if (load) begin
			cmd_o <= in_cmd_i;
		end
	end

endmodule

// File: rtl/memctl_top.sv
// Top level of the memory-system control unit: decode, execute and result stages
`timescale 1ns/1ps

module memctl_top (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  evt_valid_i,
	input  memctl_pkg::mc_event_t evt_i,
	output logic                  evt_ready_o,
	output logic                  cmd_valid_o,
	output memctl_pkg::mc_cmd_t   cmd_o,
	input  logic                  cmd_ready_i,
	output logic                  sync_req_o,
	input  logic                  sync_done_i,
	output logic                  busy_o
);

	// Decode to execute
	logic                dec_valid;
	memctl_pkg::mc_cmd_t dec_cmd;
	logic                exe_ready;
	// Execute to result
	logic                exe_valid;
	memctl_pkg::mc_cmd_t exe_cmd;
	logic                res_ready;

	memctl_decode u_decode (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.evt_valid_i (evt_valid_i),
		.evt_i       (evt_i),
		.evt_ready_o (evt_ready_o),
		.cmd_valid_o (dec_valid),
		.cmd_o       (dec_cmd),
		.cmd_ready_i (exe_ready)
	);

	memctl_execute u_execute (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (dec_valid),
		.in_cmd_i    (dec_cmd),
		.in_ready_o  (exe_ready),
		.out_valid_o (exe_valid),
		.out_cmd_o   (exe_cmd),
		.out_ready_i (res_ready),
		.sync_req_o  (sync_req_o),
		.sync_done_i (sync_done_i)
	);

	memctl_result u_result (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (exe_valid),
		.in_cmd_i    (exe_cmd),
		.in_ready_o  (res_ready),
		.cmd_valid_o (cmd_valid_o),
		.cmd_o       (cmd_o),
		.cmd_ready_i (cmd_ready_i)
	);

	// Execute also holds a command while it waits on L2
	assign busy_o = dec_valid | exe_valid | sync_req_o | cmd_valid_o;

endmodule

// File: dv/tb_clkgen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	// 10 ns period
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// Reset low for 5 cycles, released away from the rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

// File: dv/tb_memctl.sv
// Stimulus, LFSR, reference model, scoreboard, L2 model and watchdog for memctl_top
`timescale 1ns/1ps
`include "memctl_params.svh"

module tb_memctl;

	// Events over all tests
	localparam int N_EVENTS = 1 + 4 + 16 + 20 + 300;
	localparam logic [31:0] FENCE_I_INSTR = {17'd0, `MC_FUNCT3_FENCE_I, 5'd0, `MC_OPCODE_FENCE};

	logic                  clk;
	logic                  rst_n;
	logic                  evt_valid_i;
	memctl_pkg::mc_event_t evt_i;
	logic                  evt_ready_o;
	logic                  cmd_valid_o;
	memctl_pkg::mc_cmd_t   cmd_o;
	logic                  cmd_ready_i;
	logic                  sync_req_o;
	logic                  sync_done_i;
	logic                  busy_o;

	// Expected commands, oldest first
	memctl_pkg::mc_cmd_t   exp_q[$];
	string                 tname;
	logic [31:0]           stim_lfsr = 32'h1d0a08b0;
	logic [31:0]           env_lfsr = 32'h1d0a08b0;
	logic [31:0]           wait_cnt;
	logic                  armed;
	logic                  stall_en;
	int                    errors, err_start, n_tests, n_fail;
	int                    n_exp, n_out, sync_in, sync_out, done_cnt;

	tb_clkgen u_clkgen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	memctl_top dut (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.evt_valid_i (evt_valid_i),
		.evt_i       (evt_i),
		.evt_ready_o (evt_ready_o),
		.cmd_valid_o (cmd_valid_o),
		.cmd_o       (cmd_o),
		.cmd_ready_i (cmd_ready_i),
		.sync_req_o  (sync_req_o),
		.sync_done_i (sync_done_i),
		.busy_o      (busy_o)
	);

	// Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Stimulus stream stepped once per bit
	function automatic logic [31:0] stim_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// Separate stream for ready stalls and L2 delays
	function automatic logic [31:0] env_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			env_lfsr = lfsr_step(env_lfsr);
			v = {v[30:0], env_lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] sfence_instr(input logic [4:0] rs1, input logic [4:0] rs2);
		return {`MC_FUNCT7_SFENCE_VMA, rs2, rs1, 3'b000, 5'd0, `MC_OPCODE_SYSTEM};
	endfunction

	// Register-register ALU op that is never a fence
	function automatic logic [31:0] ordinary_instr();
		logic [31:0] r;
		r = stim_bits(25);
		return {r[24:0], 7'b0110011};
	endfunction

	// Operand page and ASID always random
	function automatic memctl_pkg::mc_event_t make_evt(input logic exc, input logic [31:0] instr,
			input logic [3:0] code);
		memctl_pkg::mc_event_t e;
		logic [31:0] r;
		e.is_except = exc;
		e.instr = instr;
		e.code = memctl_pkg::except_code_e'(code);
		r = stim_bits(`MC_ASID_LEN);
		e.asid = r[`MC_ASID_LEN-1:0];
		r = stim_bits(`MC_VPN_LEN);
		e.vpn = r[`MC_VPN_LEN-1:0];
		return e;
	endfunction

	function automatic memctl_pkg::mc_event_t rand_evt();
		memctl_pkg::mc_event_t e;
		logic [31:0] kind;
		logic [31:0] r;
		kind = stim_bits(2);
		r = stim_bits(12);
		case (kind[1:0])
			2'd0: e = make_evt(1'b1, ordinary_instr(), r[3:0]);
			2'd1: e = make_evt(1'b0, FENCE_I_INSTR, 4'd0);
			// Each index zero about half the time
			2'd2: e = make_evt(1'b0, sfence_instr(r[0] ? r[5:1] : 5'd0, r[6] ? r[11:7] : 5'd0), 4'd0);
			default: e = make_evt(1'b0, ordinary_instr(), 4'd0);
		endcase
		return e;
	endfunction

	// All-zero expected command means no action
	function automatic memctl_pkg::mc_cmd_t ref_cmd(input memctl_pkg::mc_event_t e);
		memctl_pkg::mc_cmd_t c;
		logic [3:0] k;
		c = '0;
		k = e.code;
		if (e.is_except) begin
			c.flush_pipe = 1'b1;
			c.clr_tlb_mshr = (k == 4'd0) || (k == 4'd1) || (k == 4'd12);
			c.clr_dmshr = ((k >= 4'd4) && (k <= 4'd7)) || (k == 4'd13) || (k == 4'd15);
			if ((k == 4'd12) || (k == 4'd13) || (k == 4'd15)) begin
				c.flush_type = memctl_pkg::FLUSH_PAGE;
				c.flush_page = e.vpn;
			end else if (k == 4'd2) begin
				c.abort = 1'b1;
				c.flush_type = memctl_pkg::FLUSH_ALL;
			end else if ((k == 4'd9) || (k == 4'd11)) begin
				c.sync_l2 = 1'b1;
				c.flush_type = memctl_pkg::FLUSH_ALL;
			end else if (!c.clr_tlb_mshr && !c.clr_dmshr) begin
				// Causes 3, 8, 10, 14
				c.flush_type = memctl_pkg::FLUSH_ALL;
			end
		end else if (e.instr[6:0] == `MC_OPCODE_FENCE && e.instr[14:12] == `MC_FUNCT3_FENCE_I) begin
			c.clr_tlb_mshr = 1'b1;
		end else if (e.instr[6:0] == `MC_OPCODE_SYSTEM && e.instr[14:12] == 3'd0 &&
				e.instr[31:25] == `MC_FUNCT7_SFENCE_VMA) begin
			c.clr_tlb_mshr = 1'b1;
			c.clr_dmshr = 1'b1;
			c.sync_l2 = 1'b1;
			if (e.instr[19:15] != 5'd0) begin
				c.flush_type = memctl_pkg::FLUSH_PAGE;
				c.flush_page = e.vpn;
			end else if (e.instr[24:20] != 5'd0) begin
				c.flush_type = memctl_pkg::FLUSH_ASID;
				c.flush_asid = e.asid;
			end else begin
				c.flush_type = memctl_pkg::FLUSH_ALL;
			end
		end
		return c;
	endfunction

	task automatic report_fault(input string msg);
		$display("%s: %s", tname, msg);
		errors++;
	endtask

	// Scoreboard sampled on the rising edge
	always @(posedge clk) begin
		memctl_pkg::mc_cmd_t c;
		if (rst_n) begin
			// Some stage holds a command exactly while one is still owed
			assert (busy_o == (exp_q.size() != 0)) else
				report_fault("busy_o disagrees with the commands in flight");
			if (evt_valid_i && evt_ready_o) begin
				c = ref_cmd(evt_i);
				if (c != '0) begin
					exp_q.push_back(c);
					n_exp++;
					sync_in += c.sync_l2 ? 1 : 0;
				end
			end
			// Request only for a sync command still owed its done pulse
			assert (!sync_req_o || sync_in > done_cnt) else
				report_fault("sync_req_o high with no sync command waiting");
			if (sync_done_i && sync_req_o) begin
				done_cnt++;
			end
			if (cmd_valid_o && cmd_ready_i) begin
				n_out++;
				if (exp_q.size() == 0) begin
					report_fault("command came out with none expected");
				end else begin
					c = exp_q.pop_front();
					assert (cmd_o == c) else begin
						$display("FAILED %s expected %h actual %h", tname, c, cmd_o);
						errors++;
					end
					sync_out += cmd_o.sync_l2 ? 1 : 0;
					assert (sync_out <= done_cnt) else
						report_fault("sync command released before sync_done_i");
				end
			end
		end
	end

	// Ready stalls and L2 update unit
	always @(negedge clk) begin
		cmd_ready_i = stall_en ? (env_bits(2) != 32'd0) : 1'b1;
		if (sync_done_i) begin
			sync_done_i = 1'b0;
			armed = 1'b0;
		end else if (sync_req_o) begin
			if (!armed) begin
				wait_cnt = env_bits(3);
				armed = 1'b1;
			end
			if (wait_cnt == 32'd0) begin
				sync_done_i = 1'b1;
			end else begin
				wait_cnt--;
			end
		end
	end

	task automatic send_event(input memctl_pkg::mc_event_t e, input int gap);
		repeat (gap) begin
			@(negedge clk);
			evt_valid_i = 1'b0;
		end
		@(negedge clk);
		evt_valid_i = 1'b1;
		evt_i = e;
		@(posedge clk);
		while (!evt_ready_o) @(posedge clk);
	endtask

	task automatic drain();
		@(negedge clk);
		evt_valid_i = 1'b0;
		while (exp_q.size() != 0 || busy_o) @(negedge clk);
	endtask

	task automatic begin_test(input string name);
		tname = name;
		err_start = errors;
		n_exp = 0;
		n_out = 0;
	endtask

	task automatic end_test();
		drain();
		assert (n_out == n_exp) else
			report_fault($sformatf("%0d commands out, %0d expected", n_out, n_exp));
		n_tests++;
		n_fail += (errors != err_start) ? 1 : 0;
		$display("test %-14s %s (%0d errors)", tname,
			(errors == err_start) ? "ok" : "FAILED", errors - err_start);
	endtask

	initial begin
		logic [31:0] r;
		evt_valid_i = 1'b0;
		evt_i = '0;
		cmd_ready_i = 1'b1;
		sync_done_i = 1'b0;
		stall_en = 1'b0;
		armed = 1'b0;
		wait_cnt = '0;
		@(posedge rst_n);
		@(negedge clk);

		begin_test("reset_fence_i");
		assert (!cmd_valid_o && !sync_req_o && !busy_o && evt_ready_o) else
			report_fault("outputs not at their reset values");
		send_event(make_evt(1'b0, FENCE_I_INSTR, 4'd0), 0);
		end_test();

		// Each rs1/rs2 zero or nonzero pairing goes alone through the sync wait
		begin_test("sfence_vma");
		for (int i = 0; i < 4; i++) begin
			send_event(make_evt(1'b0, sfence_instr(i[0] ? 5'd7 : 5'd0, i[1] ? 5'd9 : 5'd0), 4'd0), 0);
			drain();
		end
		end_test();

		begin_test("exceptions");
		for (int k = 0; k < 16; k++) begin
			send_event(make_evt(1'b1, ordinary_instr(), k[3:0]), 0);
		end
		end_test();

		begin_test("ordinary");
		for (int i = 0; i < 20; i++) begin
			send_event(make_evt(1'b0, ordinary_instr(), 4'd0), 0);
		end
		end_test();

		begin_test("random_mix");
		stall_en = 1'b1;
		for (int i = 0; i < 300; i++) begin
			r = stim_bits(2);
			send_event(rand_evt(), r);
		end
		end_test();

		$display("Tests: %0d run, %0d failed, %0d failed checks", n_tests, n_fail, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Run length bound
	initial begin
		repeat (N_EVENTS * 40) @(posedge clk);
		$display("Watchdog: run did not finish within %0d cycles", N_EVENTS * 40);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/memctl_pkg.sv
rtl/memctl_decode.sv
rtl/memctl_execute.sv
rtl/memctl_result.sv
rtl/memctl_top.sv
dv/tb_clkgen.sv
dv/tb_memctl.sv

// File: Bender.yml
package:
  name: memctl

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/memctl_pkg.sv
      - rtl/memctl_decode.sv
      - rtl/memctl_execute.sv
      - rtl/memctl_result.sv
      - rtl/memctl_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/tb_clkgen.sv
      - dv/tb_memctl.sv
